//--- common/dispatch_settings.svh
`ifndef DISPATCH_SETTINGS_SVH
`define DISPATCH_SETTINGS_SVH

// Datapath and register pointer widths
`define DISPATCH_DATA_W 32
`define DISPATCH_PTR_W 5

// General register file depth
`define DISPATCH_GR_COUNT 32

// A source reading PCR sees the PC of the instruction minus this
`define DISPATCH_PCR_READ_OFFSET 32'd4

// IRQ entry clears PSR bits 6, 5 and 2
`define DISPATCH_PSR_IRQ_MASK 32'hffff_ff9b

`endif

//--- common/isa_pkg.sv
`default_nettype none

`include "dispatch_settings.svh"

package isa_pkg;

	// Register number, general or system
	typedef logic [`DISPATCH_PTR_W-1:0] reg_ptr_t;

	// System registers kept by this stage
	typedef enum logic [4:0] {
		TIDR = 5'd2,
		PCR = 5'd4,
		SPR = 5'd5,
		PSR = 5'd6,
		IDTR = 5'd7,
		PPSR = 5'd12,
		PPCR = 5'd13
	} sysreg_idx_e;

	// Execution unit that takes the instruction
	typedef enum logic [3:0] {
		NONE = 4'd0,
		LOGIC = 4'd1,
		SHIFT = 4'd2,
		ADDER = 4'd3,
		MUL = 4'd4,
		SDIV = 4'd5,
		UDIV = 4'd6,
		LDST = 4'd7,
		BRANCH = 4'd8,
		SYS_REG = 4'd9,
		SYS_LDST = 4'd10
	} exec_unit_e;

endpackage

`default_nettype wire

//--- common/pipe_pkg.sv
`default_nettype none

`include "dispatch_settings.svh"

package pipe_pkg;

	typedef struct packed {
		logic pagefault;
		logic privilege_error;
		logic invalid_inst;
	} fault_t;

	// Instruction as handed over by decode
	typedef struct packed {
		logic valid;
		fault_t fault;
		logic [4:0] cmd;
		logic [3:0] cc_afe;
		isa_pkg::reg_ptr_t destination;
		logic destination_sysreg;
		logic writeback;
		logic flags_writeback;
		isa_pkg::reg_ptr_t source0;
		logic source0_sysreg;
		logic source0_flags;
		// Immediate, or a pointer in the low bits
		logic [`DISPATCH_DATA_W-1:0] source1;
		logic source1_sysreg;
		logic source1_imm;
		isa_pkg::exec_unit_e unit;
		logic [`DISPATCH_DATA_W-1:0] pc;
	} decoded_t;

	// Latched instruction with its operand values
	typedef struct packed {
		fault_t fault;
		logic [4:0] cmd;
		logic [3:0] cc_afe;
		isa_pkg::reg_ptr_t destination;
		logic destination_sysreg;
		logic writeback;
		logic flags_writeback;
		logic source0_sysreg;
		logic source0_flags;
		logic source1_sysreg;
		logic source1_imm;
		isa_pkg::exec_unit_e unit;
		logic [`DISPATCH_DATA_W-1:0] pc;
		logic [`DISPATCH_DATA_W-1:0] source0_value;
		logic [`DISPATCH_DATA_W-1:0] source1_value;
		isa_pkg::reg_ptr_t source0_ptr;
		isa_pkg::reg_ptr_t source1_ptr;
	} dispatched_t;

	typedef struct packed {
		logic valid;
		logic [`DISPATCH_DATA_W-1:0] data;
		isa_pkg::reg_ptr_t destination;
		logic destination_sysreg;
		logic writeback;
		logic spr_writeback;
		logic [`DISPATCH_DATA_W-1:0] spr;
		logic [`DISPATCH_DATA_W-1:0] pc;
		logic branch;
		logic [`DISPATCH_DATA_W-1:0] branch_pc;
	} writeback_t;

	// Controls from the exception and free unit
	typedef struct packed {
		logic refresh;
		logic pipeline_stop;
		logic set_irq_mode;
		logic clr_irq_mode;
		logic ppcr_set;
		logic [`DISPATCH_DATA_W-1:0] ppcr;
	} free_ctrl_t;

	typedef struct packed {
		logic [`DISPATCH_DATA_W-1:0] psr;
		logic [`DISPATCH_DATA_W-1:0] ppsr;
		logic [`DISPATCH_DATA_W-1:0] spr;
		logic [`DISPATCH_DATA_W-1:0] pcr;
		logic [`DISPATCH_DATA_W-1:0] ppcr;
		logic [`DISPATCH_DATA_W-1:0] idtr;
		logic [`DISPATCH_DATA_W-1:0] tidr;
	} sysreg_view_t;

endpackage

`default_nettype wire

//--- source/gr_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_settings.svh"

module gr_file (
	input logic iCLOCK,
	input logic inRESET,
	input logic wr_en,
	input logic [`DISPATCH_PTR_W-1:0] wr_ptr,
	input logic [`DISPATCH_DATA_W-1:0] wr_data,
	input logic [`DISPATCH_PTR_W-1:0] rd0_ptr,
	input logic [`DISPATCH_PTR_W-1:0] rd1_ptr,
	output logic [`DISPATCH_DATA_W-1:0] rd0,
	output logic [`DISPATCH_DATA_W-1:0] rd1
);

	logic [`DISPATCH_DATA_W-1:0] regs [0:`DISPATCH_GR_COUNT-1];

	// Single write-back port
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < `DISPATCH_GR_COUNT; i++) begin
				regs[i] <= '0;
			end
		end
		else if (wr_en) begin
			regs[wr_ptr] <= wr_data;
		end
	end

	// Reads see the old value, bypass is done outside
	assign rd0 = regs[rd0_ptr];
	assign rd1 = regs[rd1_ptr];

	a_wr_ptr_known: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		wr_en |-> !$isunknown(wr_ptr)
	);

endmodule

`default_nettype wire

//--- sysreg/sysreg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_settings.svh"

module sysreg_file (
	input logic iCLOCK,
	input logic inRESET,
	input pipe_pkg::writeback_t wb,
	input pipe_pkg::free_ctrl_t free,
	input isa_pkg::sysreg_idx_e rd0_idx,
	input isa_pkg::sysreg_idx_e rd1_idx,
	input logic [`DISPATCH_DATA_W-1:0] cur_pc,
	output logic [`DISPATCH_DATA_W-1:0] rd0,
	output logic [`DISPATCH_DATA_W-1:0] rd1,
	output pipe_pkg::sysreg_view_t sysregs
);

	import isa_pkg::*;
	import pipe_pkg::*;

	sysreg_view_t regs;
	sysreg_idx_e wr_idx;
	logic sys_wr;
	logic pcr_wr;
	logic spr_wb;

	assign wr_idx = sysreg_idx_e'(wb.destination);

	// Data write-back into a system register
	assign sys_wr = wb.valid && wb.destination_sysreg && wb.writeback && !free.pipeline_stop;

	// PCR follows every accepted write-back
	assign pcr_wr = wb.valid && !free.pipeline_stop;

	assign spr_wb = wb.valid && wb.spr_writeback && !free.pipeline_stop;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			regs <= '0;
		end
		else begin
			if (pcr_wr) begin
				regs.pcr <= wb.branch ? wb.branch_pc : wb.pc;
			end

			// Stack pointer update from the unit wins over a plain write
			if (spr_wb) begin
				regs.spr <= wb.spr;
			end
			else if (sys_wr && wr_idx == SPR) begin
				regs.spr <= wb.data;
			end

			// IRQ entry, then IRQ exit, then software write
			if (free.set_irq_mode) begin
				regs.psr <= regs.psr & `DISPATCH_PSR_IRQ_MASK;
			end
			else if (free.clr_irq_mode) begin
				regs.psr <= regs.ppsr;
			end
			else if (sys_wr && wr_idx == PSR) begin
				regs.psr <= wb.data;
			end

			// Old PSR is saved on IRQ entry
			if (free.set_irq_mode) begin
				regs.ppsr <= regs.psr;
			end
			else if (sys_wr && wr_idx == PPSR) begin
				regs.ppsr <= wb.data;
			end

			if (free.ppcr_set) begin
				regs.ppcr <= free.ppcr;
			end
			else if (sys_wr && wr_idx == PPCR) begin
				regs.ppcr <= wb.data;
			end

			if (sys_wr && wr_idx == IDTR) begin
				regs.idtr <= wb.data;
			end

			if (sys_wr && wr_idx == TIDR) begin
				regs.tidr <= wb.data;
			end
		end
	end

	function automatic logic [`DISPATCH_DATA_W-1:0] read_sr(input sysreg_idx_e idx);
		logic [`DISPATCH_DATA_W-1:0] value;
		case (idx)
			TIDR: value = regs.tidr;
			// PC of the reading instruction, not the PCR register
			PCR: value = cur_pc - `DISPATCH_PCR_READ_OFFSET;
			SPR: value = regs.spr;
			PSR: value = regs.psr;
			IDTR: value = regs.idtr;
			PPSR: value = regs.ppsr;
			PPCR: value = regs.ppcr;
			default: value = '0;
		endcase
		return value;
	endfunction

	always_comb begin
		rd0 = read_sr(rd0_idx);
		rd1 = read_sr(rd1_idx);
	end

	assign sysregs = regs;

	// Entry and exit in one cycle would leave PSR undefined
	a_irq_mode_excl: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		!(free.set_irq_mode && free.clr_irq_mode)
	);

endmodule

`default_nettype wire

//--- source/operand_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_settings.svh"

module operand_select (
	input pipe_pkg::decoded_t prev,
	input pipe_pkg::writeback_t wb,
	input logic [`DISPATCH_DATA_W-1:0] gr_rd0,
	input logic [`DISPATCH_DATA_W-1:0] gr_rd1,
	input logic [`DISPATCH_DATA_W-1:0] sr_rd0,
	input logic [`DISPATCH_DATA_W-1:0] sr_rd1,
	output isa_pkg::reg_ptr_t gr_ptr0,
	output isa_pkg::reg_ptr_t gr_ptr1,
	output isa_pkg::sysreg_idx_e sr_idx0,
	output isa_pkg::sysreg_idx_e sr_idx1,
	output logic [`DISPATCH_DATA_W-1:0] source0_value,
	output logic [`DISPATCH_DATA_W-1:0] source1_value
);

	import isa_pkg::*;
	import pipe_pkg::*;

	typedef struct packed {
		logic hit;
		logic [`DISPATCH_DATA_W-1:0] value;
	} bypass_t;

	reg_ptr_t ptr1;
	bypass_t byp0;
	bypass_t byp1;

	// Source 1 pointer sits in the low bits of the immediate field
	assign ptr1 = prev.source1[`DISPATCH_PTR_W-1:0];

	assign gr_ptr0 = prev.source0;
	assign gr_ptr1 = ptr1;
	assign sr_idx0 = sysreg_idx_e'(prev.source0);
	assign sr_idx1 = sysreg_idx_e'(ptr1);

	// Forwarding from the write-back in flight this cycle
	function automatic bypass_t wb_bypass(input reg_ptr_t ptr, input logic sysreg);
		bypass_t r;
		r.hit = 1'b0;
		r.value = '0;
		if (sysreg) begin
			if (wb.valid && wb.destination_sysreg) begin
				if (ptr == PCR) begin
					r = '{hit: 1'b1, value: wb.pc};
				end
				else if (ptr == SPR && wb.spr_writeback) begin
					r = '{hit: 1'b1, value: wb.spr};
				end
				else if (ptr == wb.destination && wb.writeback) begin
					r = '{hit: 1'b1, value: wb.data};
				end
			end
		end
		else if (wb.valid && wb.writeback && !wb.destination_sysreg && ptr == wb.destination) begin
			r = '{hit: 1'b1, value: wb.data};
		end
		return r;
	endfunction

	always_comb begin
		byp0 = wb_bypass(prev.source0, prev.source0_sysreg);
		byp1 = wb_bypass(ptr1, prev.source1_sysreg);
	end

	assign source0_value = byp0.hit ? byp0.value :
		(prev.source0_sysreg ? sr_rd0 : gr_rd0);

	// Immediate overrides everything
	assign source1_value = prev.source1_imm ? prev.source1 :
		byp1.hit ? byp1.value :
		(prev.source1_sysreg ? sr_rd1 : gr_rd1);

endmodule

`default_nettype wire

//--- source/dispatch_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_settings.svh"

module dispatch_stage (
	input logic iCLOCK,
	input logic inRESET,
	input pipe_pkg::decoded_t prev,
	input logic [`DISPATCH_DATA_W-1:0] source0_value,
	input logic [`DISPATCH_DATA_W-1:0] source1_value,
	input logic wb_valid,
	input logic refresh,
	input logic pipeline_stop,
	input logic next_lock,
	output pipe_pkg::dispatched_t next,
	output logic next_valid,
	output logic prev_lock,
	output logic exception_lock
);

	import isa_pkg::*;
	import pipe_pkg::*;

	dispatched_t latch_d;
	dispatched_t latch_q;
	logic valid_q;
	logic pcr_valid_q;

	always_comb begin
		latch_d.fault = prev.fault;
		latch_d.cmd = prev.cmd;
		latch_d.cc_afe = prev.cc_afe;
		latch_d.destination = prev.destination;
		latch_d.destination_sysreg = prev.destination_sysreg;
		latch_d.writeback = prev.writeback;
		latch_d.flags_writeback = prev.flags_writeback;
		latch_d.source0_sysreg = prev.source0_sysreg;
		latch_d.source0_flags = prev.source0_flags;
		latch_d.source1_sysreg = prev.source1_sysreg;
		latch_d.source1_imm = prev.source1_imm;
		latch_d.unit = prev.unit;
		latch_d.pc = prev.pc;
		latch_d.source0_value = source0_value;
		latch_d.source1_value = source1_value;
		latch_d.source0_ptr = prev.source0;
		latch_d.source1_ptr = prev.source1[`DISPATCH_PTR_W-1:0];
	end

	// Flush beats lock, lock holds everything
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			valid_q <= 1'b0;
			latch_q <= '0;
		end
		else if (refresh) begin
			valid_q <= 1'b0;
			latch_q <= '0;
		end
		else if (!next_lock) begin
			valid_q <= prev.valid;
			latch_q <= latch_d;
		end
	end

	// PCR holds a real PC only after the first write-back
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			pcr_valid_q <= 1'b0;
		end
		else if (refresh) begin
			pcr_valid_q <= 1'b0;
		end
		else if (wb_valid && !pipeline_stop) begin
			pcr_valid_q <= 1'b1;
		end
	end

	assign next = latch_q;
	assign next_valid = valid_q && !next_lock;
	assign prev_lock = next_lock;
	assign exception_lock = !pcr_valid_q || !valid_q || latch_q.unit == BRANCH;

	// Lock level gates next_valid and the latch directly
	a_lock_known: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		!$isunknown(next_lock)
	);

endmodule

`default_nettype wire

//--- source/dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "dispatch_settings.svh"

module dispatch (
	input logic iCLOCK,
	input logic inRESET,
	input pipe_pkg::decoded_t prev,
	input pipe_pkg::writeback_t wb,
	input pipe_pkg::free_ctrl_t free,
	input logic next_lock,
	output pipe_pkg::dispatched_t next,
	output logic next_valid,
	output logic prev_lock,
	output logic exception_lock,
	output pipe_pkg::sysreg_view_t sysregs
);

	import isa_pkg::*;
	import pipe_pkg::*;

	logic gr_wr_en;
	reg_ptr_t gr_ptr0;
	reg_ptr_t gr_ptr1;
	sysreg_idx_e sr_idx0;
	sysreg_idx_e sr_idx1;
	logic [`DISPATCH_DATA_W-1:0] gr_rd0;
	logic [`DISPATCH_DATA_W-1:0] gr_rd1;
	logic [`DISPATCH_DATA_W-1:0] sr_rd0;
	logic [`DISPATCH_DATA_W-1:0] sr_rd1;
	logic [`DISPATCH_DATA_W-1:0] source0_value;
	logic [`DISPATCH_DATA_W-1:0] source1_value;

	// General register write-back, held off by a pipeline stop
	assign gr_wr_en = wb.valid && !wb.destination_sysreg && wb.writeback && !free.pipeline_stop;

	gr_file u_gr_file (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.wr_en(gr_wr_en),
		.wr_ptr(wb.destination),
		.wr_data(wb.data),
		.rd0_ptr(gr_ptr0),
		.rd1_ptr(gr_ptr1),
		.rd0(gr_rd0),
		.rd1(gr_rd1)
	);

	sysreg_file u_sysreg_file (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.wb(wb),
		.free(free),
		.rd0_idx(sr_idx0),
		.rd1_idx(sr_idx1),
		.cur_pc(prev.pc),
		.rd0(sr_rd0),
		.rd1(sr_rd1),
		.sysregs(sysregs)
	);

	operand_select u_operand_select (
		.prev(prev),
		.wb(wb),
		.gr_rd0(gr_rd0),
		.gr_rd1(gr_rd1),
		.sr_rd0(sr_rd0),
		.sr_rd1(sr_rd1),
		.gr_ptr0(gr_ptr0),
		.gr_ptr1(gr_ptr1),
		.sr_idx0(sr_idx0),
		.sr_idx1(sr_idx1),
		.source0_value(source0_value),
		.source1_value(source1_value)
	);

	dispatch_stage u_dispatch_stage (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.prev(prev),
		.source0_value(source0_value),
		.source1_value(source1_value),
		.wb_valid(wb.valid),
		.refresh(free.refresh),
		.pipeline_stop(free.pipeline_stop),
		.next_lock(next_lock),
		.next(next),
		.next_valid(next_valid),
		.prev_lock(prev_lock),
		.exception_lock(exception_lock)
	);

endmodule

`default_nettype wire

//--- verif/tb_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dispatch;

	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int RESET_CYCLES = 10;
	localparam int STIM_CYCLES = 3000;
	// Run length plus some slack
	localparam int MAX_CYCLES = (RESET_CYCLES + STIM_CYCLES) * 7 / 6;
	// PSR bits 6, 5 and 2 drop on IRQ entry
	localparam logic [31:0] IRQ_CLEAR = 32'h0000_0064;

	logic iCLOCK;
	logic inRESET;
	decoded_t prev;
	writeback_t wb;
	free_ctrl_t free;
	logic next_lock;
	dispatched_t next;
	logic next_valid;
	logic prev_lock;
	logic exception_lock;
	sysreg_view_t sysregs;

	logic [31:0] seed;
	int checks;
	int errors;
	int timeout_cycles;

	// Reference model state
	logic [31:0] m_gr [0:31];
	sysreg_view_t m_sr;
	logic m_pcr_valid;
	logic m_valid;
	logic [31:0] m_src0;
	logic [31:0] m_src1;
	logic [31:0] m_pc;
	exec_unit_e m_unit;
	reg_ptr_t m_ptr0;
	reg_ptr_t m_ptr1;
	decoded_t m_inst;

	dispatch u_dut (.*);

	always #50 iCLOCK = ~iCLOCK;

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// Mostly implemented indexes, now and then an unknown one
	function automatic logic [4:0] pick_sysreg(input logic [3:0] sel);
		logic [4:0] idx;
		case (sel[2:0])
			3'd0: idx = 5'd2;
			3'd1: idx = 5'd4;
			3'd2: idx = 5'd5;
			3'd3: idx = 5'd6;
			3'd4: idx = 5'd7;
			3'd5: idx = 5'd12;
			3'd6: idx = 5'd13;
			default: idx = sel[3] ? 5'd9 : 5'd0;
		endcase
		return idx;
	endfunction

	function automatic logic [31:0] model_source(input logic [4:0] ptr, input logic sysreg);
		logic [31:0] value;
		logic sr_wb;
		sr_wb = wb.valid && wb.destination_sysreg;
		if (sysreg) begin
			if (sr_wb && ptr == 5'd4) value = wb.pc;
			else if (sr_wb && ptr == 5'd5 && wb.spr_writeback) value = wb.spr;
			else if (sr_wb && wb.writeback && ptr == wb.destination) value = wb.data;
			else begin
				case (ptr)
					5'd2: value = m_sr.tidr;
					5'd4: value = prev.pc - 32'd4;
					5'd5: value = m_sr.spr;
					5'd6: value = m_sr.psr;
					5'd7: value = m_sr.idtr;
					5'd12: value = m_sr.ppsr;
					5'd13: value = m_sr.ppcr;
					default: value = '0;
				endcase
			end
		end
		else if (wb.valid && wb.writeback && !wb.destination_sysreg && ptr == wb.destination)
			value = wb.data;
		else
			value = m_gr[ptr];
		return value;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Fail %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic drive_random();
		logic [31:0] r;
		decoded_t p;
		writeback_t w;
		free_ctrl_t f;
		r = next_rand();
		p = '0;
		w = '0;
		f = '0;
		p.valid = r[31:29] != 3'd0;
		p.fault = r[28:26];
		p.cmd = r[25:21];
		p.cc_afe = r[20:17];
		p.destination = r[16:12];
		p.writeback = r[11];
		p.source0_sysreg = r[10:9] == 2'd0;
		p.source1_sysreg = r[8:7] == 2'd0;
		p.source1_imm = r[6:5] == 2'd0;
		p.unit = exec_unit_e'(r[3:0] % 4'd11);
		r = next_rand();
		p.source0 = p.source0_sysreg ? pick_sysreg(r[31:28]) : r[4:0];
		p.pc = {r[27:0], 4'b0000};
		p.source1 = next_rand();
		if (p.source1_sysreg && !p.source1_imm) p.source1[4:0] = pick_sysreg(r[23:20]);
		r = next_rand();
		w.valid = r[31];
		w.destination_sysreg = r[30:29] == 2'd0;
		w.writeback = r[28:27] != 2'd0;
		w.spr_writeback = r[26:24] == 3'd0;
		w.branch = r[23:22] == 2'd0;
		// Often aim at the register that source 0 reads
		if (r[21:20] == 2'd0) w.destination = p.source0;
		else if (w.destination_sysreg) w.destination = pick_sysreg(r[19:16]);
		else w.destination = r[4:0];
		w.data = next_rand();
		w.spr = next_rand();
		w.pc = next_rand() & 32'hffff_fffc;
		w.branch_pc = next_rand() & 32'hffff_fffc;
		r = next_rand();
		f.refresh = r[31:27] == 5'd0;
		f.pipeline_stop = r[26:24] == 3'd0;
		f.set_irq_mode = r[23:20] == 4'd0;
		f.clr_irq_mode = !f.set_irq_mode && r[19:16] == 4'd0;
		f.ppcr_set = r[15:12] == 4'd0;
		f.ppcr = next_rand();
		// Control bits that only travel through the latch
		p.destination_sysreg = r[9];
		p.flags_writeback = r[8];
		p.source0_flags = r[7];
		prev = p;
		wb = w;
		free = f;
		next_lock = r[11:10] == 2'd0;
	endtask

	// State after the coming rising edge
	task automatic model_step();
		logic [31:0] old_psr;
		logic [31:0] src0;
		logic [31:0] src1;
		logic wb_ok;
		logic sys_we;
		src0 = model_source(prev.source0, prev.source0_sysreg);
		src1 = prev.source1_imm ? prev.source1 :
			model_source(prev.source1[4:0], prev.source1_sysreg);
		if (free.refresh) begin
			m_valid = 1'b0;
			{m_src0, m_src1, m_pc, m_ptr0, m_ptr1} = '0;
			m_unit = NONE;
			m_inst = '0;
		end
		else if (!next_lock) begin
			m_valid = prev.valid;
			m_src0 = src0;
			m_src1 = src1;
			m_pc = prev.pc;
			m_unit = prev.unit;
			m_ptr0 = prev.source0;
			m_ptr1 = prev.source1[4:0];
			m_inst = prev;
		end
		wb_ok = wb.valid && !free.pipeline_stop;
		sys_we = wb_ok && wb.writeback && wb.destination_sysreg;
		if (free.refresh) m_pcr_valid = 1'b0;
		else if (wb_ok) m_pcr_valid = 1'b1;
		if (wb_ok && wb.writeback && !wb.destination_sysreg) m_gr[wb.destination] = wb.data;
		if (wb_ok) m_sr.pcr = wb.branch ? wb.branch_pc : wb.pc;
		if (wb_ok && wb.spr_writeback) m_sr.spr = wb.spr;
		else if (sys_we && wb.destination == 5'd5) m_sr.spr = wb.data;
		old_psr = m_sr.psr;
		if (free.set_irq_mode) m_sr.psr = old_psr & ~IRQ_CLEAR;
		else if (free.clr_irq_mode) m_sr.psr = m_sr.ppsr;
		else if (sys_we && wb.destination == 5'd6) m_sr.psr = wb.data;
		if (free.set_irq_mode) m_sr.ppsr = old_psr;
		else if (sys_we && wb.destination == 5'd12) m_sr.ppsr = wb.data;
		if (free.ppcr_set) m_sr.ppcr = free.ppcr;
		else if (sys_we && wb.destination == 5'd13) m_sr.ppcr = wb.data;
		if (sys_we && wb.destination == 5'd7) m_sr.idtr = wb.data;
		if (sys_we && wb.destination == 5'd2) m_sr.tidr = wb.data;
	endtask

	task automatic check_outputs();
		compare_value("next_valid", 32'(next_valid), 32'(m_valid && !next_lock));
		compare_value("prev_lock", 32'(prev_lock), 32'(next_lock));
		compare_value("exception_lock", 32'(exception_lock),
			32'(!m_pcr_valid || !m_valid || m_unit == BRANCH));
		compare_value("next.source0_value", next.source0_value, m_src0);
		compare_value("next.source1_value", next.source1_value, m_src1);
		compare_value("next.pc", next.pc, m_pc);
		compare_value("next.unit", 32'(next.unit), 32'(m_unit));
		compare_value("next.source0_ptr", 32'(next.source0_ptr), 32'(m_ptr0));
		compare_value("next.source1_ptr", 32'(next.source1_ptr), 32'(m_ptr1));
		compare_value("next.fault", 32'(next.fault), 32'(m_inst.fault));
		compare_value("next.cmd", 32'(next.cmd), 32'(m_inst.cmd));
		compare_value("next.cc_afe", 32'(next.cc_afe), 32'(m_inst.cc_afe));
		compare_value("next.destination", 32'(next.destination),
			32'(m_inst.destination));
		compare_value("next.destination_sysreg", 32'(next.destination_sysreg),
			32'(m_inst.destination_sysreg));
		compare_value("next.writeback", 32'(next.writeback), 32'(m_inst.writeback));
		compare_value("next.flags_writeback", 32'(next.flags_writeback),
			32'(m_inst.flags_writeback));
		compare_value("next.source0_sysreg", 32'(next.source0_sysreg),
			32'(m_inst.source0_sysreg));
		compare_value("next.source0_flags", 32'(next.source0_flags),
			32'(m_inst.source0_flags));
		compare_value("next.source1_sysreg", 32'(next.source1_sysreg),
			32'(m_inst.source1_sysreg));
		compare_value("next.source1_imm", 32'(next.source1_imm), 32'(m_inst.source1_imm));
		compare_value("sysregs.psr", sysregs.psr, m_sr.psr);
		compare_value("sysregs.ppsr", sysregs.ppsr, m_sr.ppsr);
		compare_value("sysregs.spr", sysregs.spr, m_sr.spr);
		compare_value("sysregs.pcr", sysregs.pcr, m_sr.pcr);
		compare_value("sysregs.ppcr", sysregs.ppcr, m_sr.ppcr);
		compare_value("sysregs.idtr", sysregs.idtr, m_sr.idtr);
		compare_value("sysregs.tidr", sysregs.tidr, m_sr.tidr);
	endtask

	initial begin
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		prev = '0;
		wb = '0;
		free = '0;
		next_lock = 1'b0;
		seed = 32'h15c65a3a;
		checks = 0;
		errors = 0;
		for (int i = 0; i < 32; i++) begin
			m_gr[i] = '0;
		end
		m_sr = '0;
		{m_pcr_valid, m_valid, m_src0, m_src1, m_pc, m_ptr0, m_ptr1} = '0;
		m_unit = NONE;
		m_inst = '0;
		repeat (RESET_CYCLES) @(posedge iCLOCK);
		@(negedge iCLOCK);
		inRESET = 1'b1;
		for (int n = 0; n < STIM_CYCLES; n++) begin
			check_outputs();
			drive_random();
			model_step();
			@(negedge iCLOCK);
		end
		check_outputs();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end
		else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	initial begin
		timeout_cycles = 0;
		while (timeout_cycles < MAX_CYCLES) begin
			@(posedge iCLOCK);
			timeout_cycles++;
		end
		$display("Timeout: stimulus still running after %0d cycles", timeout_cycles);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- dispatch.f
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
source/gr_file.sv
sysreg/sysreg_file.sv
source/operand_select.sv
source/dispatch_stage.sv
source/dispatch.sv
verif/tb_dispatch.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_dispatch
FILELIST ?= dispatch.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := common/dispatch_settings.svh

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
